// File: logic/execPkg.sv
package execPkg;

    localparam int xlen = 64;
    localparam int divSteps = xlen;
    localparam int divCntW = $clog2(divSteps);

    typedef logic [xlen-1:0] wordT;

    // instruction kinds the execute stage has to tell apart
    typedef enum logic [3:0] {
        SLL, SRL, SRA,
        SLLW, SRLW, SRAW,
        JAL, JALR, BRANCH,
        CSRRW, CSRRS, CSRRC,
        LOAD, STORE,
        OTHER
    } instrOpT;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU,
        ALU_MUL,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } aluFuncT;

    typedef enum logic [1:0] {
        CSRW,
        CSRS,
        CSRC
    } csrFuncT;

    typedef enum logic [1:0] {
        MSIZE1,
        MSIZE2,
        MSIZE4,
        MSIZE8
    } msizeT;

    // mcause encodings
    typedef enum logic [4:0] {
        INSTR_ADDR_MISALIGNED = 5'd0,
        INSTR_ACCESS_FAULT    = 5'd1,
        ILLEGAL_INSTR         = 5'd2,
        BREAKPOINT            = 5'd3,
        LOAD_ADDR_MISALIGNED  = 5'd4,
        LOAD_ACCESS_FAULT     = 5'd5,
        STORE_ADDR_MISALIGNED = 5'd6,
        STORE_ACCESS_FAULT    = 5'd7,
        ECALL_U               = 5'd8,
        ECALL_S               = 5'd9,
        ECALL_M               = 5'd11,
        NONE                  = 5'd31
    } excCodeT;

    typedef struct packed {
        logic    exception;
        excCodeT code;
        wordT    value;
    } exceptionDataT;

    typedef struct packed {
        instrOpT     op;
        aluFuncT     func;
        logic        word;
        csrFuncT     csrFunc;
        logic        srcaR;
        logic        srcbR;
        logic        csrR;
        logic        jump;
        logic        btype;
        logic        memRead;
        logic        memWrite;
        msizeT       msize;
        logic        memUnsigned;
        logic        regWrite;
        logic [4:0]  dst;
        logic        csrWrite;
        logic [11:0] csrDst;
    } ctlT;

    typedef struct packed {
        logic          valid;
        wordT          pc;
        logic [31:0]   instruction;
        wordT          srca;
        wordT          srcb;
        wordT          imm;
        wordT          pcData;
        wordT          memData;
        wordT          csra;
        wordT          csrb;
        ctlT           ctl;
        exceptionDataT exData;
    } decodeDataT;

    typedef struct packed {
        logic rs1Sel;
        wordT rs1Data;
        logic rs2Sel;
        wordT rs2Data;
        logic csrSel;
        wordT csrData;
    } forwardT;

    typedef struct packed {
        logic          valid;
        wordT          pc;
        logic [31:0]   instruction;
        wordT          result;
        wordT          memData;
        wordT          jAddr;
        wordT          csrData;
        logic [4:0]    dst;
        logic [11:0]   csrDst;
        logic          jump;
        logic          regWrite;
        logic          memRead;
        logic          memWrite;
        logic          csrWrite;
        msizeT         msize;
        logic          memUnsigned;
        instrOpT       op;
        exceptionDataT exData;
    } executeDataT;

endpackage

// File: logic/csrAlu.sv
`timescale 1ns/1ps

module csrAlu import execPkg::*; (
    input  wordT    a,
    input  wordT    b,
    input  csrFuncT func,
    output wordT    c
);

    // a is the old csr value, b the operand
    // clear arrives with b already inverted
    always_comb begin
        case (func)
            CSRW: begin
                c = b;
            end
            CSRS: begin
                c = a | b;
            end
            CSRC: begin
                c = a & b;
            end
            default: begin
                c = b;
            end
        endcase
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import execPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  wordT    a,
    input  wordT    b,
    input  aluFuncT func,
    input  logic    word,
    output logic    done,
    output wordT    c
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FINISH
    } divStateT;

    divStateT           divState;
    logic [divCntW-1:0] stepCnt;
    logic               isDiv;
    logic               isSigned;
    logic               isRem;
    logic               hold;
    logic               blocked;
    logic               divStart;
    wordT               divA;
    wordT               divB;
    wordT               absA;
    wordT               absB;
    wordT               quo;
    wordT               rem;
    wordT               divisor;
    wordT               dividend;
    logic               quoNeg;
    logic               remNeg;
    logic               divZero;
    wordT               lastA;
    wordT               lastB;
    wordT               quoOut;
    wordT               remOut;
    wordT               res;

    // one restoring step, returns {rem, quo}
    function automatic logic [2*xlen-1:0] divStep(
        input wordT r,
        input wordT q,
        input wordT d
    );
        logic [xlen:0] trial;
        logic [xlen:0] diff;
        trial = {r, q[xlen-1]};
        diff = trial - {1'b0, d};
        if (trial >= {1'b0, d}) begin
            return {diff[xlen-1:0], q[xlen-2:0], 1'b1};
        end
        return {trial[xlen-1:0], q[xlen-2:0], 1'b0};
    endfunction

    assign isDiv = func inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    assign isSigned = func inside {ALU_DIV, ALU_REM};
    assign isRem = func inside {ALU_REM, ALU_REMU};

    // word ops divide the extended low halves
    always_comb begin
        if (!word) begin
            divA = a;
            divB = b;
        end else if (isSigned) begin
            divA = {{(xlen-32){a[31]}}, a[31:0]};
            divB = {{(xlen-32){b[31]}}, b[31:0]};
        end else begin
            divA = {{(xlen-32){1'b0}}, a[31:0]};
            divB = {{(xlen-32){1'b0}}, b[31:0]};
        end
    end

    assign absA = (isSigned && divA[xlen-1]) ? -divA : divA;
    assign absB = (isSigned && divB[xlen-1]) ? -divB : divB;

    // same division still presented after finishing
    assign blocked = hold && isDiv && (a == lastA) && (b == lastB);
    assign divStart = isDiv && (divState == DIV_IDLE) && !blocked;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            divState <= DIV_IDLE;
            stepCnt <= '0;
            hold <= 1'b0;
        end else begin
            case (divState)
                DIV_IDLE: begin
                    if (divStart) begin
                        divState <= DIV_RUN;
                        stepCnt <= divCntW'(1);
                    end
                end
                DIV_RUN: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == divCntW'(divSteps - 1)) begin
                        divState <= DIV_FINISH;
                    end
                end
                DIV_FINISH: divState <= DIV_IDLE;
                default: divState <= DIV_IDLE;
            endcase
            hold <= (divState == DIV_FINISH) ? 1'b1 : blocked;
        end
    end

    // first step is taken on the start edge
    always_ff @(posedge clk) begin
        if (divStart) begin
            {rem, quo} <= divStep('0, absA, absB);
            divisor <= absB;
            dividend <= divA;
            quoNeg <= isSigned && (divA[xlen-1] ^ divB[xlen-1]);
            remNeg <= isSigned && divA[xlen-1];
            divZero <= (divB == '0);
        end else if (divState == DIV_RUN) begin
            {rem, quo} <= divStep(rem, quo, divisor);
        end
        if (divState == DIV_FINISH) begin
            lastA <= a;
            lastB <= b;
        end
    end

    // signed overflow falls out of the magnitude path unchanged
    assign quoOut = divZero ? '1 : (quoNeg ? -quo : quo);
    assign remOut = divZero ? dividend : (remNeg ? -rem : rem);

    always_comb begin
        case (func)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = word ? {{(xlen-32){1'b0}}, a[31:0] << b[4:0]} : a << b[5:0];
            ALU_SRL:  res = word ? {{(xlen-32){1'b0}}, a[31:0] >> b[4:0]} : a >> b[5:0];
            ALU_SRA: begin
                if (word) begin
                    res = {{(xlen-32){1'b0}}, $signed(a[31:0]) >>> b[4:0]};
                end else begin
                    res = $signed(a) >>> b[5:0];
                end
            end
            ALU_SLT:  res = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: res = {{(xlen-1){1'b0}}, a < b};
            ALU_SEQ:  res = {{(xlen-1){1'b0}}, a == b};
            ALU_SNE:  res = {{(xlen-1){1'b0}}, a != b};
            ALU_SGE:  res = {{(xlen-1){1'b0}}, $signed(a) >= $signed(b)};
            ALU_SGEU: res = {{(xlen-1){1'b0}}, a >= b};
            ALU_MUL:  res = a * b;
            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: res = isRem ? remOut : quoOut;
            default:  res = '0;
        endcase
    end

    assign c = word ? {{(xlen-32){res[31]}}, res[31:0]} : res;
    assign done = isDiv ? (divState == DIV_FINISH) : 1'b1;

endmodule

// File: logic/execute.sv
`timescale 1ns/1ps

module execute import execPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  decodeDataT  dataD,
    input  forwardT     fwd,
    output logic        dataOk,
    output executeDataT dataE
);

    wordT          srca;
    wordT          srcb;
    wordT          csrb;
    wordT          pcData;
    wordT          memData;
    wordT          result;
    wordT          csrResult;
    logic          done;
    aluFuncT       aluFunc;
    logic          faulted;
    logic          misaligned;
    exceptionDataT alignEx;

    // bubbles run as a plain add so the divider stays idle
    always_comb begin
        if (dataD.valid) begin
            aluFunc = dataD.ctl.func;
        end else begin
            aluFunc = ALU_ADD;
        end
    end

    alu aluUnit (
        .clk(clk),
        .rstN(rstN),
        .a(srca),
        .b(srcb),
        .func(aluFunc),
        .word(dataD.ctl.word),
        .done(done),
        .c(result)
    );

    csrAlu csrUnit (
        .a(dataD.csra),
        .b(csrb),
        .func(dataD.ctl.csrFunc),
        .c(csrResult)
    );

    assign pcData = fwd.rs1Sel ? fwd.rs1Data : dataD.pcData;
    assign memData = fwd.rs2Sel ? fwd.rs2Data : dataD.memData;
    assign srca = (dataD.ctl.srcaR && fwd.rs1Sel) ? fwd.rs1Data : dataD.srca;

    // forwarded shift amounts need masking, decode already did it otherwise
    always_comb begin
        if (dataD.ctl.srcbR && fwd.rs2Sel) begin
            if (dataD.ctl.op inside {SLL, SRL, SRA}) begin
                srcb = {{(xlen-6){1'b0}}, fwd.rs2Data[5:0]};
            end else if (dataD.ctl.op inside {SLLW, SRLW, SRAW}) begin
                srcb = {{(xlen-5){1'b0}}, fwd.rs2Data[4:0]};
            end else begin
                srcb = fwd.rs2Data;
            end
        end else begin
            srcb = dataD.srcb;
        end
    end

    assign csrb = (dataD.ctl.csrR && fwd.csrSel)
        ? ((dataD.ctl.op == CSRRC) ? ~fwd.csrData : fwd.csrData)
        : dataD.csrb;

    assign faulted = dataD.exData.exception;

    always_comb begin
        case (dataD.ctl.msize)
            MSIZE2:  misaligned = result[0];
            MSIZE4:  misaligned = |result[1:0];
            MSIZE8:  misaligned = |result[2:0];
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        alignEx.exception = 1'b0;
        alignEx.code = NONE;
        alignEx.value = '0;
        if ((dataD.ctl.memRead || dataD.ctl.memWrite) && misaligned) begin
            alignEx.exception = 1'b1;
            alignEx.value = result;
            if (dataD.ctl.memRead) begin
                alignEx.code = LOAD_ADDR_MISALIGNED;
            end else begin
                alignEx.code = STORE_ADDR_MISALIGNED;
            end
        end
    end

    always_comb begin
        dataE.valid = dataD.valid;
        dataE.pc = dataD.pc;
        dataE.instruction = dataD.instruction;
        dataE.result = result;
        dataE.memData = memData;
        dataE.csrData = csrResult;
        if (dataD.ctl.op == JALR) begin
            dataE.jAddr = (pcData + dataD.imm) & ~wordT'(1);
        end else begin
            dataE.jAddr = dataD.pc + dataD.imm;
        end
        dataE.msize = dataD.ctl.msize;
        dataE.op = dataD.ctl.op;
        // a faulting instruction leaves no side effects
        dataE.jump = !faulted
            && (dataD.ctl.jump || (dataD.ctl.btype && result == wordT'(1)));
        dataE.regWrite = !faulted && dataD.ctl.regWrite;
        dataE.memRead = !faulted && dataD.ctl.memRead;
        dataE.memWrite = !faulted && dataD.ctl.memWrite;
        dataE.csrWrite = !faulted && dataD.ctl.csrWrite;
        dataE.memUnsigned = !faulted && dataD.ctl.memUnsigned;
        dataE.dst = faulted ? '0 : dataD.ctl.dst;
        dataE.csrDst = faulted ? '0 : dataD.ctl.csrDst;
        dataE.exData = faulted ? dataD.exData : alignEx;
    end

    assign dataOk = done;

endmodule

// File: logic/executeStage.sv
`timescale 1ns/1ps

module executeStage import execPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  decodeDataT  dataD,
    input  forwardT     fwd,
    output logic        dataOk,
    output executeDataT dataM
);

    executeDataT dataE;

    execute execUnit (
        .clk(clk),
        .rstN(rstN),
        .dataD(dataD),
        .fwd(fwd),
        .dataOk(dataOk),
        .dataE(dataE)
    );

    // execute to memory register
    always_ff @(posedge clk) begin
        if (dataOk) begin
            dataM <= dataE;
        end
        if (!rstN) begin
            dataM.valid <= 1'b0;
            dataM.jump <= 1'b0;
            dataM.regWrite <= 1'b0;
            dataM.memRead <= 1'b0;
            dataM.memWrite <= 1'b0;
            dataM.csrWrite <= 1'b0;
        end else if (!dataOk) begin
            // stalled, send a bubble downstream
            dataM.valid <= 1'b0;
        end
    end

endmodule

// File: test/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

function automatic wordT sext32(wordT x);
    return {{32{x[31]}}, x[31:0]};
endfunction

// riscv division rules, word variants divide the extended low halves
function automatic wordT divResult(aluFuncT f, logic w, wordT a, wordT b);
    logic sgn;
    wordT x;
    wordT y;
    wordT q;
    wordT r;
    sgn = f inside {ALU_DIV, ALU_REM};
    x = w ? (sgn ? sext32(a) : {32'd0, a[31:0]}) : a;
    y = w ? (sgn ? sext32(b) : {32'd0, b[31:0]}) : b;
    if (y == '0) begin
        q = '1;
        r = x;
    end else if (sgn && x == {1'b1, {(xlen-1){1'b0}}} && y == '1) begin
        q = x;
        r = '0;
    end else if (sgn) begin
        q = $signed(x) / $signed(y);
        r = $signed(x) % $signed(y);
    end else begin
        q = x / y;
        r = x % y;
    end
    return (f inside {ALU_REM, ALU_REMU}) ? r : q;
endfunction

function automatic wordT aluResult(aluFuncT f, logic w, wordT a, wordT b);
    wordT r;
    logic [31:0] a32;
    int sh;
    a32 = a[31:0];
    sh = w ? int'(b[4:0]) : int'(b[5:0]);
    case (f)
        ALU_ADD:  r = a + b;
        ALU_SUB:  r = a - b;
        ALU_AND:  r = a & b;
        ALU_OR:   r = a | b;
        ALU_XOR:  r = a ^ b;
        ALU_SLL:  r = a << sh;
        ALU_SRL:  r = w ? wordT'(a32 >> sh) : a >> sh;
        ALU_SRA:  r = w ? wordT'($signed(a32) >>> sh) : wordT'($signed(a) >>> sh);
        ALU_SLT:  r = wordT'($signed(a) < $signed(b));
        ALU_SLTU: r = wordT'(a < b);
        ALU_SEQ:  r = wordT'(a == b);
        ALU_SNE:  r = wordT'(a != b);
        ALU_SGE:  r = wordT'($signed(a) >= $signed(b));
        ALU_SGEU: r = wordT'(a >= b);
        ALU_MUL:  r = a * b;
        default:  r = divResult(f, w, a, b);
    endcase
    return w ? sext32(r) : r;
endfunction

// operand here is the real mask, never inverted
function automatic wordT csrResult(csrFuncT f, wordT old, wordT operand);
    case (f)
        CSRS:    return old | operand;
        CSRC:    return old & ~operand;
        default: return operand;
    endcase
endfunction

function automatic exceptionDataT alignFault(ctlT c, wordT addr);
    exceptionDataT x;
    wordT bytes;
    bytes = wordT'(1) << int'(c.msize);
    x.exception = 1'b0;
    x.code = NONE;
    x.value = '0;
    if ((c.memRead || c.memWrite) && (addr % bytes) != '0) begin
        x.exception = 1'b1;
        x.code = c.memRead ? LOAD_ADDR_MISALIGNED : STORE_ADDR_MISALIGNED;
        x.value = addr;
    end
    return x;
endfunction

function automatic executeDataT expectOut(decodeDataT d, forwardT f);
    executeDataT e;
    wordT opA;
    wordT opB;
    wordT rs1;
    wordT csrOp;
    logic ok;
    ok = !d.exData.exception;
    opA = (d.ctl.srcaR && f.rs1Sel) ? f.rs1Data : d.srca;
    opB = (d.ctl.srcbR && f.rs2Sel) ? f.rs2Data : d.srcb;
    rs1 = f.rs1Sel ? f.rs1Data : d.pcData;
    if (d.ctl.csrR && f.csrSel) begin
        csrOp = f.csrData;
    end else begin
        // decode hands the clear mask over inverted
        csrOp = (d.ctl.op == CSRRC) ? ~d.csrb : d.csrb;
    end
    e = '0;
    e.valid = d.valid;
    e.pc = d.pc;
    e.instruction = d.instruction;
    e.result = aluResult(d.ctl.func, d.ctl.word, opA, opB);
    e.memData = f.rs2Sel ? f.rs2Data : d.memData;
    e.jAddr = (d.ctl.op == JALR) ? ((rs1 + d.imm) & ~wordT'(1)) : d.pc + d.imm;
    e.csrData = csrResult(d.ctl.csrFunc, d.csra, csrOp);
    e.jump = ok && (d.ctl.jump || (d.ctl.btype && e.result == wordT'(1)));
    e.regWrite = ok && d.ctl.regWrite;
    e.memRead = ok && d.ctl.memRead;
    e.memWrite = ok && d.ctl.memWrite;
    e.csrWrite = ok && d.ctl.csrWrite;
    e.memUnsigned = ok && d.ctl.memUnsigned;
    e.dst = ok ? d.ctl.dst : 5'd0;
    e.csrDst = ok ? d.ctl.csrDst : 12'd0;
    e.msize = d.ctl.msize;
    e.op = d.ctl.op;
    e.exData = ok ? alignFault(d.ctl, e.result) : d.exData;
    return e;
endfunction

`endif

// File: test/executeTb.sv
`timescale 1ns/1ps

module executeTb import execPkg::*; ();

    logic        clk;
    logic        rstN;
    decodeDataT  dataD;
    forwardT     fwd;
    logic        dataOk;
    executeDataT dataM;
    executeDataT expM;
    logic        checkNow = 1'b0;
    logic        timedOut = 1'b0;
    int          errCount = 0;
    int          errAtStart = 0;
    int          testPass = 0;
    int          testFail = 0;

    `include "refModel.svh"

    executeStage UUT (
        .clk(clk),
        .rstN(rstN),
        .dataD(dataD),
        .fwd(fwd),
        .dataOk(dataOk),
        .dataM(dataM)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic reportMismatch(string what, wordT got, wordT want);
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
        errCount++;
    endtask

    function automatic wordT sideEffects(executeDataT e);
        return wordT'({e.jump, e.regWrite, e.memRead, e.memWrite, e.csrWrite,
            e.memUnsigned, e.dst, e.csrDst, e.msize, e.op});
    endfunction

    // sampled on the falling edge after a capture
    checkValid: assert property (@(negedge clk) checkNow |-> dataM.valid
            && dataM.pc == expM.pc && dataM.instruction == expM.instruction)
        else reportMismatch("valid/pc", dataM.pc, expM.pc);
    checkResult: assert property (@(negedge clk) checkNow |-> dataM.result == expM.result)
        else reportMismatch("result", dataM.result, expM.result);
    checkMemData: assert property (@(negedge clk) checkNow |-> dataM.memData == expM.memData)
        else reportMismatch("memData", dataM.memData, expM.memData);
    checkTarget: assert property (@(negedge clk) checkNow |-> dataM.jAddr == expM.jAddr)
        else reportMismatch("jAddr", dataM.jAddr, expM.jAddr);
    checkCsr: assert property (@(negedge clk) checkNow |-> dataM.csrData == expM.csrData)
        else reportMismatch("csrData", dataM.csrData, expM.csrData);
    checkFlags: assert property (@(negedge clk) checkNow
            |-> sideEffects(dataM) == sideEffects(expM))
        else reportMismatch("flags", sideEffects(dataM), sideEffects(expM));
    checkCause: assert property (@(negedge clk) checkNow
            |-> dataM.exData.exception == expM.exData.exception
            && dataM.exData.code == expM.exData.code)
        else reportMismatch("exception cause", wordT'(dataM.exData.code),
            wordT'(expM.exData.code));
    checkExcValue: assert property (@(negedge clk) checkNow
            |-> dataM.exData.value == expM.exData.value)
        else reportMismatch("exception value", dataM.exData.value, expM.exData.value);

    function automatic wordT randWord();
        return {$urandom, $urandom};
    endfunction

    function automatic decodeDataT makeItem(instrOpT op, aluFuncT func, logic word,
                                            wordT a, wordT b);
        decodeDataT d;
        d = '0;
        d.valid = 1'b1;
        d.pc = randWord() & ~wordT'(3);
        d.instruction = $urandom;
        d.srca = a;
        d.srcb = b;
        d.imm = b;
        d.ctl.op = op;
        d.ctl.func = func;
        d.ctl.word = word;
        d.ctl.srcaR = 1'b1;
        d.ctl.srcbR = 1'b1;
        d.ctl.regWrite = 1'b1;
        d.ctl.dst = 5'($urandom_range(31, 1));
        d.exData.code = NONE;
        return d;
    endfunction

    // present one item and hold it until dataOk before the capture check
    task automatic runItem(input decodeDataT d, input forwardT f);
        int cycles;
        int wantCycles;
        if (timedOut) return;
        @(posedge clk);
        dataD <= d;
        fwd <= f;
        expM = expectOut(d, f);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dataOk && cycles < 200);
        if (!dataOk) begin
            $display("timeout: dataOk stayed low for 200 cycles at %0t", $time);
            timedOut = 1'b1;
            return;
        end
        wantCycles = (d.ctl.func inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU})
            ? divSteps + 1 : 1;
        latency: assert (cycles == wantCycles)
            else reportMismatch("latency", wordT'(cycles), wordT'(wantCycles));
        @(posedge clk);
        dataD <= '0;
        fwd <= '0;
        checkNow <= 1'b1;
        @(posedge clk);
        checkNow <= 1'b0;
    endtask

    task automatic reportTest(string name);
        if (errCount != errAtStart || timedOut) begin
            $display("%s: failed with %0d errors", name, errCount - errAtStart);
            testFail++;
        end else begin
            $display("%s: passed", name);
            testPass++;
        end
        errAtStart = errCount;
    endtask

    task automatic arithmetic();
        @(negedge clk);
        resetValid: assert (!dataM.valid && !dataM.jump && !dataM.regWrite
                && !dataM.memRead && !dataM.memWrite && !dataM.csrWrite)
            else reportMismatch("valid and write flags after reset",
                wordT'({dataM.valid, dataM.jump, dataM.regWrite, dataM.memRead,
                    dataM.memWrite, dataM.csrWrite}), '0);
        for (int i = 0; i <= int'(ALU_MUL); i++) begin
            for (int w = 0; w < 4; w++) begin
                runItem(makeItem(OTHER, aluFuncT'(i), w[0], randWord(), randWord()), '0);
            end
        end
        reportTest("arithmetic");
    endtask

    task automatic forwarding();
        decodeDataT d;
        forwardT f;
        f = '0;
        f.rs1Sel = 1'b1;
        f.rs1Data = randWord();
        f.rs2Sel = 1'b1;
        f.rs2Data = randWord();
        d = makeItem(OTHER, ALU_ADD, 1'b0, randWord(), randWord());
        d.memData = randWord();
        runItem(d, f);
        runItem(makeItem(SLL, ALU_SLL, 1'b0, randWord(), 64'd3), f);
        runItem(makeItem(SRLW, ALU_SRL, 1'b1, randWord(), 64'd7), f);
        reportTest("forwarding");
    endtask

    task automatic division();
        wordT minVal;
        for (int i = int'(ALU_DIV); i <= int'(ALU_REMU); i++) begin
            for (int w = 0; w < 2; w++) begin
                minVal = w[0] ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
                runItem(makeItem(OTHER, aluFuncT'(i), w[0], randWord(), randWord()), '0);
                runItem(makeItem(OTHER, aluFuncT'(i), w[0], randWord(),
                    randWord() >> $urandom_range(62, 20)), '0);
                runItem(makeItem(OTHER, aluFuncT'(i), w[0], randWord(), '0), '0);
                runItem(makeItem(OTHER, aluFuncT'(i), w[0], minVal, '1), '0);
            end
        end
        reportTest("division");
    endtask

    task automatic controlFlow();
        decodeDataT d;
        forwardT f;
        wordT a;
        a = randWord();
        for (int t = 0; t < 2; t++) begin
            d = makeItem(BRANCH, ALU_SEQ, 1'b0, a, a ^ wordT'(t));
            d.ctl.btype = 1'b1;
            d.ctl.regWrite = 1'b0;
            d.imm = randWord() & ~wordT'(1);
            runItem(d, '0);
        end
        d = makeItem(JAL, ALU_ADD, 1'b0, randWord(), 64'd4);
        d.ctl.jump = 1'b1;
        d.imm = randWord() & ~wordT'(1);
        runItem(d, '0);
        d = makeItem(JALR, ALU_ADD, 1'b0, randWord(), 64'd4);
        d.ctl.jump = 1'b1;
        d.imm = randWord() & ~wordT'(1);
        d.pcData = randWord();
        f = '0;
        f.rs1Sel = 1'b1;
        f.rs1Data = randWord() | wordT'(1);
        runItem(d, f);
        reportTest("control flow");
    endtask

    task automatic alignment();
        decodeDataT d;
        for (int m = 0; m < 4; m++) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < 4; k++) begin
                    d = makeItem((s == 1) ? STORE : LOAD, ALU_ADD, 1'b0, randWord(),
                        wordT'($urandom_range(15, 0)));
                    d.ctl.srcbR = 1'b0;
                    d.ctl.msize = msizeT'(m);
                    d.ctl.memRead = (s == 0);
                    d.ctl.memWrite = (s == 1);
                    d.ctl.regWrite = (s == 0);
                    d.memData = randWord();
                    runItem(d, '0);
                end
            end
        end
        // earlier fault must win over a misaligned address
        d = makeItem(STORE, ALU_ADD, 1'b0, randWord() | wordT'(1), 64'd0);
        d.ctl.msize = MSIZE8;
        d.ctl.memWrite = 1'b1;
        d.ctl.jump = 1'b1;
        d.ctl.csrWrite = 1'b1;
        d.ctl.memUnsigned = 1'b1;
        d.ctl.csrDst = 12'($urandom);
        d.exData.exception = 1'b1;
        d.exData.code = ILLEGAL_INSTR;
        d.exData.value = randWord();
        runItem(d, '0);
        reportTest("alignment");
    endtask

    task automatic csrAccess();
        decodeDataT d;
        forwardT f;
        wordT mask;
        for (int k = 0; k < 3; k++) begin
            for (int useFwd = 0; useFwd < 2; useFwd++) begin
                mask = randWord();
                d = makeItem(instrOpT'(int'(CSRRW) + k), ALU_ADD, 1'b0, randWord(), randWord());
                d.ctl.csrFunc = csrFuncT'(k);
                d.ctl.csrR = 1'b1;
                d.ctl.csrWrite = 1'b1;
                d.ctl.csrDst = 12'($urandom);
                d.csra = randWord();
                f = '0;
                if (useFwd == 1) begin
                    f.csrSel = 1'b1;
                    f.csrData = mask;
                    d.csrb = randWord();
                end else begin
                    d.csrb = (k == 2) ? ~mask : mask;
                end
                runItem(d, f);
            end
        end
        reportTest("csr");
    endtask

    initial begin
        void'($urandom(92));
        rstN = 1'b0;
        // a valid item with write flags set is held through reset
        dataD = makeItem(OTHER, ALU_ADD, 1'b0, randWord(), randWord());
        dataD.ctl.jump = 1'b1;
        dataD.ctl.memRead = 1'b1;
        dataD.ctl.memWrite = 1'b1;
        dataD.ctl.csrWrite = 1'b1;
        fwd = '0;
        expM = '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        dataD <= '0;
        arithmetic();
        forwarding();
        division();
        controlFlow();
        alignment();
        csrAccess();
        $display("tests passed %0d, failed %0d, errors %0d", testPass, testFail, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+test
logic/execPkg.sv
logic/csrAlu.sv
logic/alu.sv
logic/execute.sv
logic/executeStage.sv
test/executeTb.sv

// File: Makefile
TOP := executeTb
RTL_TOP := executeStage

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)
	verilator --lint-only logic/execPkg.sv logic/csrAlu.sv logic/alu.sv \
		logic/execute.sv logic/executeStage.sv --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir
